/* motor_regs_pkg.sv */
package motor_regs_pkg;

	// Avalon word address width of the control slave
	localparam int ADDR_W = 4;

	// Register offset width inside one channel block
	localparam int OFS_W = 2;

	// Identification word returned at address 0
	localparam logic [31:0] MOTOR_ID = 32'hEA680003;

	localparam logic [ADDR_W-1:0] REG_ID = ADDR_W'(0);

	// First register of channel 0
	localparam logic [ADDR_W-1:0] CH_BASE = ADDR_W'(1);

	// The stride is a power of two so the channel index is a bit field
	localparam logic [ADDR_W-1:0] CH_STRIDE = ADDR_W'(1 << OFS_W);

	localparam logic [OFS_W-1:0] OFS_FREQ = OFS_W'(0);   // Phase increment
	localparam logic [OFS_W-1:0] OFS_WIDTH = OFS_W'(1);  // Compare threshold
	localparam logic [OFS_W-1:0] OFS_ON = OFS_W'(2);     // Bit 0 enables the bridge
	localparam logic [OFS_W-1:0] OFS_DIR = OFS_W'(3);    // Bit 0 selects hx, else hy

endpackage

/* motor_pwm_pkg.sv */
package motor_pwm_pkg;

	// Number of independent motor channels
	localparam int NUM_CH = 2;

	// Width of the channel index field in a register address
	localparam int CH_W = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;

	// Accumulator, frequency and width size
	localparam int PHASE_W = 32;

	// Cycles with both half-bridge inputs low after a direction change
	localparam int DEAD_CYCLES = 4;

	localparam int DEAD_CNT_W = (DEAD_CYCLES > 1) ? $clog2(DEAD_CYCLES) : 1;

	// Last count of the dead-time gap, the new side is taken after it
	localparam logic [DEAD_CNT_W-1:0] DEAD_LAST = DEAD_CNT_W'(DEAD_CYCLES - 1);

endpackage

/* motor_cfg_if.sv */
`timescale 1ns/1ps

// One channel's settings, held as levels until the register bank rewrites them
interface motor_cfg_if;

	logic [motor_pwm_pkg::PHASE_W-1:0] freq;   // Phase increment per cycle
	logic [motor_pwm_pkg::PHASE_W-1:0] width;  // Compare threshold
	logic on;
	logic dir;
	logic phase_clr;  // One-cycle pulse after any frequency byte write

	modport csr (
		output freq,
		output width,
		output on,
		output dir,
		output phase_clr
	);

	modport pwm (
		input freq,
		input width,
		input phase_clr
	);

	modport bridge (
		input on,
		input dir
	);

endinterface

/* motor_csr.sv */
`timescale 1ns/1ps

module motor_csr (
	input  logic                               csi_MCLK_clk,
	input  logic                               rsi_MRST_reset,
	input  logic [31:0]                        avs_ctrl_writedata,
	input  logic [3:0]                         avs_ctrl_byteenable,
	input  logic [motor_regs_pkg::ADDR_W-1:0]  avs_ctrl_address,
	input  logic                               avs_ctrl_write,
	input  logic                               avs_ctrl_read,
	output logic [31:0]                        avs_ctrl_readdata,
	motor_cfg_if.csr                           cfg [motor_pwm_pkg::NUM_CH]
);

	logic [motor_pwm_pkg::PHASE_W-1:0] freq_q [motor_pwm_pkg::NUM_CH];
	logic [motor_pwm_pkg::PHASE_W-1:0] width_q [motor_pwm_pkg::NUM_CH];
	logic [motor_pwm_pkg::NUM_CH-1:0] on_q;
	logic [motor_pwm_pkg::NUM_CH-1:0] dir_q;
	logic [motor_pwm_pkg::NUM_CH-1:0] clr_q;

	logic [motor_regs_pkg::ADDR_W-1:0] rel_addr;
	logic [motor_pwm_pkg::CH_W-1:0] ch_sel;
	logic [motor_regs_pkg::OFS_W-1:0] ofs_sel;
	logic ch_hit;

	// Replace only the bytes whose enable is set
	function automatic logic [31:0] be_merge(
		input logic [31:0] old_val,
		input logic [31:0] new_val,
		input logic [3:0]  be
	);
		logic [31:0] res;
		res = old_val;
		for (int b = 0; b < 4; b++) begin
			if (be[b])
				res[8*b +: 8] = new_val[8*b +: 8];
		end
		return res;
	endfunction

	// Split the address into channel and offset relative to channel 0
	always_comb begin
		rel_addr = avs_ctrl_address - motor_regs_pkg::CH_BASE;
		ofs_sel = rel_addr[motor_regs_pkg::OFS_W-1:0];
		ch_sel = rel_addr[motor_regs_pkg::OFS_W +: motor_pwm_pkg::CH_W];
		ch_hit = (avs_ctrl_address >= motor_regs_pkg::CH_BASE) &&
			(int'(rel_addr[motor_regs_pkg::ADDR_W-1:motor_regs_pkg::OFS_W]) <
			motor_pwm_pkg::NUM_CH);
	end

	always_ff @(posedge csi_MCLK_clk or posedge rsi_MRST_reset) begin
		if (rsi_MRST_reset) begin
			for (int c = 0; c < motor_pwm_pkg::NUM_CH; c++) begin
				freq_q[c] <= '0;
				width_q[c] <= '0;
			end
			on_q <= '0;
			dir_q <= '0;
			clr_q <= '0;
		end else begin
			clr_q <= '0;
			if (avs_ctrl_write && ch_hit) begin
				case (ofs_sel)
					motor_regs_pkg::OFS_FREQ: begin
						freq_q[ch_sel] <= be_merge(freq_q[ch_sel], avs_ctrl_writedata,
							avs_ctrl_byteenable);
						clr_q[ch_sel] <= |avs_ctrl_byteenable;  // Restart the phase on new frequency
					end
					motor_regs_pkg::OFS_WIDTH:
						width_q[ch_sel] <= be_merge(width_q[ch_sel], avs_ctrl_writedata,
							avs_ctrl_byteenable);
					motor_regs_pkg::OFS_ON:  on_q[ch_sel] <= avs_ctrl_writedata[0];
					default:                 dir_q[ch_sel] <= avs_ctrl_writedata[0];
				endcase
			end
		end
	end

	// Read data is registered and held until the next read
	always_ff @(posedge csi_MCLK_clk or posedge rsi_MRST_reset) begin
		if (rsi_MRST_reset) begin
			avs_ctrl_readdata <= '0;
		end else if (avs_ctrl_read) begin
			if (avs_ctrl_address == motor_regs_pkg::REG_ID) begin
				avs_ctrl_readdata <= motor_regs_pkg::MOTOR_ID;
			end else if (ch_hit) begin
				case (ofs_sel)
					motor_regs_pkg::OFS_FREQ:  avs_ctrl_readdata <= freq_q[ch_sel];
					motor_regs_pkg::OFS_WIDTH: avs_ctrl_readdata <= width_q[ch_sel];
					motor_regs_pkg::OFS_ON:    avs_ctrl_readdata <= {31'b0, on_q[ch_sel]};
					default:                   avs_ctrl_readdata <= {31'b0, dir_q[ch_sel]};
				endcase
			end else begin
				avs_ctrl_readdata <= '0;  // Unmapped addresses read as zero
			end
		end
	end

	for (genvar c = 0; c < motor_pwm_pkg::NUM_CH; c++) begin : g_cfg
		assign cfg[c].freq = freq_q[c];
		assign cfg[c].width = width_q[c];
		assign cfg[c].on = on_q[c];
		assign cfg[c].dir = dir_q[c];
		assign cfg[c].phase_clr = clr_q[c];

		// The host never writes the same frequency register on back-to-back cycles
		a_clr_pulse: assert property (@(posedge csi_MCLK_clk) disable iff (rsi_MRST_reset)
			clr_q[c] |=> !clr_q[c])
			else $error("phase_clr of channel %0d held for more than one cycle", c);
	end

	// The master issues at most one transfer per cycle
	a_no_rd_wr: assert property (@(posedge csi_MCLK_clk) disable iff (rsi_MRST_reset)
		!(avs_ctrl_write && avs_ctrl_read))
		else $error("Avalon read and write asserted together");

endmodule

/* pwm_accum.sv */
`timescale 1ns/1ps

// Phase-accumulator PWM for one channel
// The output is high while the phase is at or below the width threshold,
// so the duty cycle is about width / 2^PHASE_W and the period is
// 2^PHASE_W / freq clock cycles
module pwm_accum (
	input  logic      csi_MCLK_clk,
	input  logic      rsi_MRST_reset,
	motor_cfg_if.pwm  cfg,
	output logic      pwm
);

	logic [motor_pwm_pkg::PHASE_W-1:0] phase;
	logic phase_low;

	// Compare against the current phase, registered below
	assign phase_low = (phase <= cfg.width);

	// Phase wraps naturally at 2^PHASE_W
	always_ff @(posedge csi_MCLK_clk or posedge rsi_MRST_reset) begin
		if (rsi_MRST_reset) begin
			phase <= '0;
		end else if (cfg.phase_clr) begin
			phase <= '0;  // Align the phase to the new frequency
		end else begin
			phase <= phase + cfg.freq;
		end
	end

	always_ff @(posedge csi_MCLK_clk or posedge rsi_MRST_reset) begin
		if (rsi_MRST_reset)
			pwm <= 1'b0;
		else
			pwm <= phase_low;
	end

endmodule

/* hbridge_steer.sv */
`timescale 1ns/1ps

// Steers one channel's PWM to hx or hy
// A direction change first blanks both sides for DEAD_CYCLES cycles, so the
// two transistors of a leg are never driven in overlapping cycles
module hbridge_steer (
	input  logic         csi_MCLK_clk,
	input  logic         rsi_MRST_reset,
	input  logic         pwm,
	motor_cfg_if.bridge  cfg,
	output logic         hx,
	output logic         hy
);

	logic applied_dir;  // Direction currently driving the bridge
	logic [motor_pwm_pkg::DEAD_CNT_W-1:0] dead_cnt;
	logic blank;
	logic drive;

	// Requested and applied direction disagree while the gap runs
	assign blank = (cfg.dir != applied_dir);
	assign drive = cfg.on && !blank && pwm;

	always_ff @(posedge csi_MCLK_clk or posedge rsi_MRST_reset) begin
		if (rsi_MRST_reset) begin
			applied_dir <= 1'b0;
			dead_cnt <= '0;
		end else if (blank) begin
			if (dead_cnt == motor_pwm_pkg::DEAD_LAST) begin
				applied_dir <= cfg.dir;  // Gap done, switch to the new side
				dead_cnt <= '0;
			end else begin
				dead_cnt <= dead_cnt + 1'b1;
			end
		end else begin
			// A request withdrawn mid-gap restarts the count on the next change
			dead_cnt <= '0;
		end
	end

	always_ff @(posedge csi_MCLK_clk or posedge rsi_MRST_reset) begin
		if (rsi_MRST_reset) begin
			hx <= 1'b0;
			hy <= 1'b0;
		end else begin
			hx <= drive && applied_dir;
			hy <= drive && !applied_dir;
		end
	end

	a_excl: assert property (@(posedge csi_MCLK_clk) disable iff (rsi_MRST_reset)
		!(hx && hy))
		else $error("hx and hy high in the same cycle");

	// A side that was just high is never followed directly by the other side
	a_gap: assert property (@(posedge csi_MCLK_clk) disable iff (rsi_MRST_reset)
		(hx |=> !hy) and (hy |=> !hx))
		else $error("Bridge switched sides without a low gap");

endmodule

/* brush_motor_driver.sv */
`timescale 1ns/1ps

// Two-channel brushed DC motor driver with an Avalon-MM control slave
module brush_motor_driver (
	input  logic                               csi_MCLK_clk,
	input  logic                               rsi_MRST_reset,
	input  logic [31:0]                        avs_ctrl_writedata,
	input  logic [3:0]                         avs_ctrl_byteenable,
	input  logic [motor_regs_pkg::ADDR_W-1:0]  avs_ctrl_address,
	input  logic                               avs_ctrl_write,
	input  logic                               avs_ctrl_read,
	output logic [31:0]                        avs_ctrl_readdata,
	output logic [motor_pwm_pkg::NUM_CH-1:0]   hx,
	output logic [motor_pwm_pkg::NUM_CH-1:0]   hy
);

	// One configuration bundle per channel
	motor_cfg_if cfg [motor_pwm_pkg::NUM_CH] ();

	motor_csr i_motor_csr (
		.csi_MCLK_clk        (csi_MCLK_clk),
		.rsi_MRST_reset      (rsi_MRST_reset),
		.avs_ctrl_writedata  (avs_ctrl_writedata),
		.avs_ctrl_byteenable (avs_ctrl_byteenable),
		.avs_ctrl_address    (avs_ctrl_address),
		.avs_ctrl_write      (avs_ctrl_write),
		.avs_ctrl_read       (avs_ctrl_read),
		.avs_ctrl_readdata   (avs_ctrl_readdata),
		.cfg                 (cfg)
	);

	for (genvar c = 0; c < motor_pwm_pkg::NUM_CH; c++) begin : g_ch
		logic pwm;

		pwm_accum i_pwm_accum (
			.csi_MCLK_clk   (csi_MCLK_clk),
			.rsi_MRST_reset (rsi_MRST_reset),
			.cfg            (cfg[c]),
			.pwm            (pwm)
		);

		hbridge_steer i_hbridge_steer (
			.csi_MCLK_clk   (csi_MCLK_clk),
			.rsi_MRST_reset (rsi_MRST_reset),
			.pwm            (pwm),
			.cfg            (cfg[c]),
			.hx             (hx[c]),
			.hy             (hy[c])
		);
	end

endmodule

/* tb_brush_motor_driver.sv */
`timescale 1ns/1ps

module tb_brush_motor_driver;

	localparam int NUM_CH = motor_pwm_pkg::NUM_CH;
	localparam int ADDR_W = motor_regs_pkg::ADDR_W;
	localparam int RESET_CYCLES = 10;
	localparam int SETTLE_CYCLES = motor_pwm_pkg::DEAD_CYCLES + 8;
	localparam int BE_ITER = 8;
	localparam int DUTY_CASES = 4;
	localparam int SWITCH_LIMIT = 4 * motor_pwm_pkg::DEAD_CYCLES + 8;
	localparam int MAX_WINDOW = 256;
	localparam int IND_SHIFT0 = 26;
	localparam int IND_SHIFT1 = 24;

	// Cycle cost of the bus tasks and of one full channel setup
	localparam int WR_CYCLES = 2;
	localparam int RD_CYCLES = 3;
	localparam int CFG_CYCLES = 4 * WR_CYCLES;

	localparam int ID_BUDGET = (1 << ADDR_W) * RD_CYCLES + 1;
	localparam int BE_BUDGET = NUM_CH * (BE_ITER * 2 + 4) * (WR_CYCLES + RD_CYCLES);
	localparam int OFF_BUDGET = NUM_CH * CFG_CYCLES + 64 + SETTLE_CYCLES;
	localparam int DUTY_BUDGET = DUTY_CASES * (CFG_CYCLES + SETTLE_CYCLES + MAX_WINDOW + WR_CYCLES);
	localparam int DIR_BUDGET = CFG_CYCLES + SETTLE_CYCLES + 2 * (WR_CYCLES + SWITCH_LIMIT + 10);
	localparam int IND_BUDGET = 2 * CFG_CYCLES + SETTLE_CYCLES + MAX_WINDOW +
		NUM_CH * (2 * WR_CYCLES + 4 * RD_CYCLES + WR_CYCLES);
	localparam int TEST_CYCLES = ID_BUDGET + BE_BUDGET + OFF_BUDGET + DUTY_BUDGET +
		DIR_BUDGET + IND_BUDGET;
	localparam int BUDGET_CYCLES = RESET_CYCLES + 2 * TEST_CYCLES;

	logic clk;
	logic rst;
	logic [31:0] writedata;
	logic [3:0] byteenable;
	logic [ADDR_W-1:0] address;
	logic write;
	logic read;
	logic [31:0] readdata;
	logic [NUM_CH-1:0] hx;
	logic [NUM_CH-1:0] hy;

	logic [31:0] rng_state;
	logic [31:0] freq_model [NUM_CH];   // Expected register contents
	logic [31:0] width_model [NUM_CH];
	int hx_count [NUM_CH];
	int hy_count [NUM_CH];

	brush_motor_driver i_brush_motor_driver (
		.csi_MCLK_clk        (clk),
		.rsi_MRST_reset      (rst),
		.avs_ctrl_writedata  (writedata),
		.avs_ctrl_byteenable (byteenable),
		.avs_ctrl_address    (address),
		.avs_ctrl_write      (write),
		.avs_ctrl_read       (read),
		.avs_ctrl_readdata   (readdata),
		.hx                  (hx),
		.hy                  (hy)
	);

	always #20 clk = ~clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual)
			fail_run($sformatf("mismatch in %s: expected %h, actual %h", name, expected, actual));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic next_random(output logic [31:0] value);
		rng_state = xorshift32(rng_state);
		value = rng_state;
	endtask

	function automatic logic [ADDR_W-1:0] reg_addr(input int ch, input int ofs);
		return ADDR_W'(int'(motor_regs_pkg::CH_BASE) + ch * int'(motor_regs_pkg::CH_STRIDE) + ofs);
	endfunction

	// High cycles in one period of 2^32/2^shift cycles
	function automatic int expected_high(input logic [31:0] width, input int shift);
		longint q;
		longint n;
		q = longint'(width >> shift) + 1;
		n = longint'(1) << (32 - shift);
		return int'((q < n) ? q : n);
	endfunction

	task automatic avs_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
		input logic [3:0] be);
		@(posedge clk);
		address <= addr;
		writedata <= data;
		byteenable <= be;
		write <= 1'b1;
		@(posedge clk);
		write <= 1'b0;
		byteenable <= 4'h0;
	endtask

	task automatic avs_read(input logic [ADDR_W-1:0] addr, output logic [31:0] result);
		@(posedge clk);
		address <= addr;
		read <= 1'b1;
		@(posedge clk);
		read <= 1'b0;
		@(negedge clk);
		result = readdata;  // Held until the next read
	endtask

	task automatic configure_channel(input int ch, input logic [31:0] freq,
		input logic [31:0] width, input logic dir, input logic on);
		avs_write(reg_addr(ch, 1), width, 4'hF);
		avs_write(reg_addr(ch, 0), freq, 4'hF);
		avs_write(reg_addr(ch, 3), 32'(dir), 4'hF);
		avs_write(reg_addr(ch, 2), 32'(on), 4'hF);
		width_model[ch] = width;
		freq_model[ch] = freq;
	endtask

	// Counts high cycles of every output, sampled away from the clock edge
	task automatic count_window(input int cycles);
		for (int c = 0; c < NUM_CH; c++) begin
			hx_count[c] = 0;
			hy_count[c] = 0;
		end
		repeat (cycles) begin
			@(negedge clk);
			for (int c = 0; c < NUM_CH; c++) begin
				if (hx[c] && hy[c])
					fail_run($sformatf("hx and hy of channel %0d were high in the same cycle", c));
				if (hx[c])
					hx_count[c]++;
				if (hy[c])
					hy_count[c]++;
			end
		end
	endtask

	task automatic test_id_reset();
		logic [31:0] rd;
		avs_read(motor_regs_pkg::REG_ID, rd);
		check("id word", motor_regs_pkg::MOTOR_ID, rd);
		for (int c = 0; c < NUM_CH; c++) begin
			for (int o = 0; o < 4; o++) begin
				avs_read(reg_addr(c, o), rd);
				check($sformatf("reset value ch%0d ofs%0d", c, o), 32'h0, rd);
			end
		end
		for (int a = int'(reg_addr(NUM_CH, 0)); a < (1 << ADDR_W); a++) begin
			avs_read(ADDR_W'(a), rd);
			check($sformatf("unused address %0d", a), 32'h0, rd);
		end
		check("reset outputs", 32'h0, 32'({hx, hy}));
	endtask

	task automatic test_byte_enable();
		logic [31:0] data;
		logic [31:0] rnd;
		logic [31:0] mask;
		logic [31:0] rd;
		for (int c = 0; c < NUM_CH; c++) begin
			for (int i = 0; i < 2 * BE_ITER; i++) begin
				next_random(data);
				next_random(rnd);
				mask = {{8{rnd[3]}}, {8{rnd[2]}}, {8{rnd[1]}}, {8{rnd[0]}}};
				avs_write(reg_addr(c, i % 2), data, rnd[3:0]);
				if (i % 2 == 0) begin
					freq_model[c] = (freq_model[c] & ~mask) | (data & mask);
					avs_read(reg_addr(c, 0), rd);
					check($sformatf("byte enable freq ch%0d", c), freq_model[c], rd);
				end else begin
					width_model[c] = (width_model[c] & ~mask) | (data & mask);
					avs_read(reg_addr(c, 1), rd);
					check($sformatf("byte enable width ch%0d", c), width_model[c], rd);
				end
			end
			// Only bit 0 of on and dir is stored
			for (int o = 2; o < 4; o++) begin
				avs_write(reg_addr(c, o), 32'hFFFF_FFFE, 4'hF);
				avs_read(reg_addr(c, o), rd);
				check($sformatf("single bit ch%0d ofs%0d cleared", c, o), 32'h0, rd);
				avs_write(reg_addr(c, o), 32'hFFFF_FFFF, 4'hF);
				avs_read(reg_addr(c, o), rd);
				check($sformatf("single bit ch%0d ofs%0d set", c, o), 32'h1, rd);
				avs_write(reg_addr(c, o), 32'h0, 4'hF);
			end
		end
	endtask

	task automatic test_disabled();
		for (int c = 0; c < NUM_CH; c++)
			configure_channel(c, 32'h1 << 26, 32'h8000_0000, 1'(c), 1'b0);
		count_window(SETTLE_CYCLES + (1 << (32 - 26)));
		for (int c = 0; c < NUM_CH; c++) begin
			check($sformatf("disabled hx ch%0d", c), 32'h0, 32'(hx_count[c]));
			check($sformatf("disabled hy ch%0d", c), 32'h0, 32'(hy_count[c]));
		end
	endtask

	task automatic test_duty();
		logic [31:0] w;
		int shift;
		int ch;
		logic dir;
		for (int i = 0; i < DUTY_CASES; i++) begin
			shift = 24 + 2 * i;
			ch = i % NUM_CH;
			dir = 1'((i >> 1) & 1);
			next_random(w);
			if (i == DUTY_CASES - 1)
				w = 32'hFFFF_FFFF;  // Full duty
			configure_channel(ch, 32'h1 << shift, w, dir, 1'b1);
			repeat (SETTLE_CYCLES) @(posedge clk);
			count_window(1 << (32 - shift));
			check($sformatf("duty shift %0d active side", shift), 32'(expected_high(w, shift)),
				32'(dir ? hx_count[ch] : hy_count[ch]));
			check($sformatf("duty shift %0d idle side", shift), 32'h0,
				32'(dir ? hy_count[ch] : hx_count[ch]));
			avs_write(reg_addr(ch, 2), 32'h0, 4'hF);
		end
	endtask

	// Old side high, then a low gap of at least DEAD_CYCLES, then only the new side
	task automatic expect_switch(input int ch, input logic new_dir);
		logic old_hi;
		logic new_hi;
		logic done;
		int gap;
		@(negedge clk);
		old_hi = new_dir ? hy[ch] : hx[ch];
		check("direction old side before switch", 32'h1, 32'(old_hi));
		avs_write(reg_addr(ch, 3), 32'(new_dir), 4'hF);
		gap = 0;
		done = 1'b0;
		for (int i = 0; i < SWITCH_LIMIT && !done; i++) begin
			@(negedge clk);
			old_hi = new_dir ? hy[ch] : hx[ch];
			new_hi = new_dir ? hx[ch] : hy[ch];
			if (old_hi && new_hi)
				fail_run("hx and hy were high together during a direction change");
			if (new_hi) begin
				if (gap < motor_pwm_pkg::DEAD_CYCLES)
					fail_run($sformatf("new side went high after only %0d low cycles", gap));
				done = 1'b1;
			end else if (!old_hi) begin
				gap++;
			end else if (gap > 0) begin
				fail_run("old side went high again during the dead time");
			end
		end
		if (!done)
			fail_run("new side never went high after a direction change");
		count_window(8);
		check("direction new side steady", 32'd8, 32'(new_dir ? hx_count[ch] : hy_count[ch]));
		check("direction old side steady", 32'd0, 32'(new_dir ? hy_count[ch] : hx_count[ch]));
	endtask

	task automatic test_direction();
		configure_channel(1, 32'h1 << 28, 32'hFFFF_FFFF, 1'b0, 1'b1);
		repeat (SETTLE_CYCLES) @(posedge clk);
		expect_switch(1, 1'b1);
		expect_switch(1, 1'b0);
		avs_write(reg_addr(1, 2), 32'h0, 4'hF);
	endtask

	task automatic test_independence();
		logic [31:0] w0;
		logic [31:0] w1;
		logic [31:0] data;
		logic [31:0] rd;
		next_random(w0);
		next_random(w1);
		configure_channel(0, 32'h1 << IND_SHIFT0, w0, 1'b1, 1'b1);
		configure_channel(1, 32'h1 << IND_SHIFT1, w1, 1'b0, 1'b1);
		repeat (SETTLE_CYCLES) @(posedge clk);
		count_window(1 << (32 - IND_SHIFT1));  // Whole periods of both channels
		check("independence ch0 hx",
			32'(expected_high(w0, IND_SHIFT0) * (1 << (IND_SHIFT0 - IND_SHIFT1))),
			32'(hx_count[0]));
		check("independence ch0 hy", 32'h0, 32'(hy_count[0]));
		check("independence ch1 hy", 32'(expected_high(w1, IND_SHIFT1)), 32'(hy_count[1]));
		check("independence ch1 hx", 32'h0, 32'(hx_count[1]));
		for (int c = 0; c < NUM_CH; c++) begin
			next_random(data);
			avs_write(reg_addr(c, 1), data, 4'hF);
			width_model[c] = data;
			next_random(data);
			avs_write(reg_addr(c, 0), data, 4'hF);
			freq_model[c] = data;
			for (int o = 0; o < NUM_CH; o++) begin
				avs_read(reg_addr(o, 0), rd);
				check($sformatf("independence freq ch%0d after ch%0d write", o, c),
					freq_model[o], rd);
				avs_read(reg_addr(o, 1), rd);
				check($sformatf("independence width ch%0d after ch%0d write", o, c),
					width_model[o], rd);
			end
			avs_write(reg_addr(c, 2), 32'h0, 4'hF);
		end
	endtask

	initial begin
		repeat (BUDGET_CYCLES) @(posedge clk);
		fail_run($sformatf("Timeout, the tests did not finish within %0d cycles", BUDGET_CYCLES));
	end

	initial begin
		clk = 1'b0;
		rst <= 1'b1;
		writedata <= 32'h0;
		byteenable <= 4'h0;
		address <= '0;
		write <= 1'b0;
		read <= 1'b0;
		rng_state = 32'heb1fbd2a;
		for (int c = 0; c < NUM_CH; c++) begin
			freq_model[c] = 32'h0;
			width_model[c] = 32'h0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		test_id_reset();
		test_byte_enable();
		test_disabled();
		test_duty();
		test_direction();
		test_independence();
		$display("Regression passed");
		$finish;
	end

endmodule

/* flist.f */
motor_regs_pkg.sv
motor_pwm_pkg.sv
motor_cfg_if.sv
motor_csr.sv
pwm_accum.sv
hbridge_steer.sv
brush_motor_driver.sv
tb_brush_motor_driver.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TB_TOP    ?= tb_brush_motor_driver
RTL_TOP   ?= brush_motor_driver
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
SIM_BIN   ?= sim_$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FLIST)
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TB_TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TB_TOP) -f $(FLIST) \
		--Mdir $(OBJ_DIR) -o $(SIM_BIN)
	./$(OBJ_DIR)/$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
